// File: sim.f
verilog/periph_pkg.sv
verilog/apb_splitter.sv
verilog/riscv_timer.sv
verilog/uart_tx_apb.sv
verilog/periph_top.sv
verification/tb_clk_gen.sv
verification/tb_periph.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_periph.sv
/*
 * testbench for the peripheral subsystem
 * random APB traffic to timer, UART and unmapped space
 * timer register model, serial receiver, compare tasks, timeout
 */

`timescale 1ns/1ps
`default_nettype none

module tb_periph;

	import periph_pkg::*;

	localparam int N_FRAMES = 4;
	localparam int MAX_RUN  = 83;
	// frames of both UART tests plus the idle frame after the rejected write
	localparam int TIMEOUT  = (N_FRAMES + 2) * UART_FRAME_BITS * UART_DIV + MAX_RUN + 2000;

	logic         clk;
	logic         rst_n;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	logic         dbg_halt;
	wire          timer_irq;
	wire          uart_tx;

	integer       seed;
	integer       err_cnt;
	integer       test_err;
	integer       pass_cnt;
	integer       fail_cnt;
	integer       cycle_cnt = 0;
	string        cur_test;
	// word i at offset TMR_MTIME + 4*i, mtime below, mtimecmp above
	logic [127:0] regs_m;
	logic [7:0]   exp_q[$];
	logic [7:0]   rx_q[$];

	tb_clk_gen clk_gen_i (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	periph_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_apb       (apb_req),
		.o_apb       (apb_rsp),
		.i_dbg_halt  (dbg_halt),
		.o_timer_irq (timer_irq),
		.o_uart_tx   (uart_tx)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT) begin
			$display("timeout: no result after %0d clock cycles", TIMEOUT);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------
	// setup cycle, then access until pready
	task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
		input logic [APB_DATA_W-1:0] wdata, output apb_rsp_t rsp);
		@(posedge clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready) begin
			@(negedge clk);
		end
		rsp = apb_rsp;
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic check_rdata(input logic [APB_DATA_W-1:0] exp, input apb_rsp_t rsp);
		if (rsp.prdata !== exp) begin
			$display("error %s: expected %h, actual %h", cur_test, exp, rsp.prdata);
			err_cnt++;
		end
	endtask

	task automatic verify_slverr(input logic exp, input apb_rsp_t rsp);
		if (rsp.pslverr !== exp) begin
			$display("error %s: expected pslverr %b, actual %b", cur_test, exp, rsp.pslverr);
			err_cnt++;
		end
	endtask

	task automatic expect_irq(input logic exp, input logic act);
		if (act !== exp) begin
			$display("error %s: expected irq %b, actual %b", cur_test, exp, act);
			err_cnt++;
		end
	endtask

	task automatic match_byte(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("error %s: expected byte %h, actual %h", cur_test, exp, act);
			err_cnt++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err = err_cnt;
	endtask

	task automatic end_test();
		if (err_cnt == test_err) begin
			pass_cnt++;
			$display("test %s: pass", cur_test);
		end else begin
			fail_cnt++;
			$display("test %s: fail with %0d errors", cur_test, err_cnt - test_err);
		end
	endtask

	// poll CSR until idle, then compare the received byte
	task automatic finish_frame();
		apb_rsp_t   rsp;
		logic [7:0] exp;
		rsp.prdata = 32'd1;
		while (rsp.prdata[0]) begin
			apb_xfer(1'b0, {SLV_UART, UART_CSR}, '0, rsp);
		end
		check_rdata(32'd0, rsp);
		exp = exp_q.pop_front();
		if (rx_q.size() == 0) begin
			$display("%s: no frame was received on the serial line", cur_test);
			err_cnt++;
		end else begin
			match_byte(exp, rx_q.pop_front());
		end
	endtask

	// --------------------
	// serial receiver, samples near the middle of each bit
	initial begin : uart_rx
		logic [7:0] data;
		@(posedge rst_n);
		forever begin
			@(negedge uart_tx);
			repeat (UART_DIV / 2) @(negedge clk);
			if (uart_tx !== 1'b0) begin
				$display("%s: start bit did not stay low", cur_test);
				err_cnt++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (UART_DIV) @(negedge clk);
				data[i] = uart_tx;
			end
			repeat (UART_DIV) @(negedge clk);
			if (uart_tx !== 1'b1) begin
				$display("error %s: expected stop bit 1, actual %b", cur_test, uart_tx);
				err_cnt++;
			end
			rx_q.push_back(data);
		end
	end

	initial begin
		apb_rsp_t              rsp;
		logic [31:0]           x;
		logic [31:0]           rd;
		logic [31:0]           lo;
		logic [31:0]           hi;
		logic [7:0]            b;
		int                    n;
		logic [SLV_SEL_W-1:0]  sel;
		logic [SLV_SEL_LO-1:0] ofs;
		seed     = 32'h1e54b300;
		err_cnt  = 0;
		test_err = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		regs_m   = '0;
		apb_req  <= '0;
		dbg_halt <= 1'b1;
		@(posedge rst_n);

		// halted timer keeps whatever is written
		start_test("timer_rw");
		for (int i = 0; i < 4; i++) begin
			regs_m[32*i +: 32] = $random(seed);
			apb_xfer(1'b1, {SLV_TIMER, TMR_MTIME + 12'(4 * i)}, regs_m[32*i +: 32], rsp);
		end
		for (int i = 0; i < 4; i++) begin
			apb_xfer(1'b0, {SLV_TIMER, TMR_MTIME + 12'(4 * i)}, '0, rsp);
			check_rdata(regs_m[32*i +: 32], rsp);
		end
		end_test();

		start_test("timer_count");
		x = ($random(seed) & 32'h0fff_ffff) | 32'h100;
		n = 20 + ({$random(seed)} % (MAX_RUN - 19));
		apb_xfer(1'b1, {SLV_TIMER, TMR_MTIMEH}, '0, rsp);
		apb_xfer(1'b1, {SLV_TIMER, TMR_MTIME}, x, rsp);
		@(posedge clk);
		dbg_halt <= 1'b0;
		repeat (n) @(posedge clk);
		dbg_halt <= 1'b1;
		apb_xfer(1'b0, {SLV_TIMER, TMR_MTIME}, '0, rsp);
		rd = rsp.prdata;
		lo = x + 32'(n / CLK_PER_TICK) - 32'd1;
		hi = x + 32'((n + CLK_PER_TICK - 1) / CLK_PER_TICK) + 32'd1;
		if (rd < lo || rd > hi) begin
			$display("error %s: expected %h to %h, actual %h", cur_test, lo, hi, rd);
			err_cnt++;
		end
		apb_xfer(1'b0, {SLV_TIMER, TMR_MTIME}, '0, rsp);
		check_rdata(rd, rsp);
		regs_m[63:0] = {32'h0, rd};
		end_test();

		// compare at or below mtime first, then all ones
		start_test("timer_irq");
		for (int r = 0; r < 2; r++) begin
			regs_m[127:64] = (r == 0) ? regs_m[63:0] - 64'({$random(seed)} % 16) : '1;
			for (int i = 3; i >= 2; i--) begin
				apb_xfer(1'b1, {SLV_TIMER, TMR_MTIME + 12'(4 * i)}, regs_m[32*i +: 32], rsp);
			end
			repeat (2) @(negedge clk);
			expect_irq(r == 0, timer_irq);
		end
		end_test();

		start_test("uart_frames");
		for (int i = 0; i < N_FRAMES; i++) begin
			b = 8'($random(seed));
			exp_q.push_back(b);
			apb_xfer(1'b1, {SLV_UART, UART_TXDATA}, {24'h0, b}, rsp);
			verify_slverr(1'b0, rsp);
			apb_xfer(1'b0, {SLV_UART, UART_CSR}, '0, rsp);
			check_rdata(32'd1, rsp);
			finish_frame();
		end
		end_test();

		start_test("uart_busy");
		b = 8'($random(seed));
		exp_q.push_back(b);
		apb_xfer(1'b1, {SLV_UART, UART_TXDATA}, {24'h0, b}, rsp);
		verify_slverr(1'b0, rsp);
		apb_xfer(1'b1, {SLV_UART, UART_TXDATA}, {24'h0, ~b}, rsp);
		verify_slverr(1'b1, rsp);
		finish_frame();
		// room for a whole frame that must not come
		repeat (UART_FRAME_BITS * UART_DIV + UART_DIV) @(posedge clk);
		if (rx_q.size() != 0) begin
			$display("%s: an extra frame followed the rejected write", cur_test);
			err_cnt++;
		end
		end_test();

		start_test("unmapped");
		for (int i = 0; i < 8; i++) begin
			sel = SLV_SEL_W'(2 + {$random(seed)} % 14);
			// offsets that would reach timer or UART registers if psel leaked
			case (i % 4)
				0:       ofs = UART_TXDATA;
				1:       ofs = TMR_MTIME;
				2:       ofs = TMR_MTIMEH;
				default: ofs = 12'($random(seed));
			endcase
			apb_xfer(i < 4, {sel, ofs}, $random(seed), rsp);
			verify_slverr(1'b1, rsp);
			check_rdata(32'd0, rsp);
		end
		for (int i = 0; i < 2; i++) begin
			apb_xfer(1'b0, {SLV_TIMER, TMR_MTIME + 12'(4 * i)}, '0, rsp);
			check_rdata(regs_m[32*i +: 32], rsp);
		end
		apb_xfer(1'b0, {SLV_UART, UART_CSR}, '0, rsp);
		check_rdata(32'd0, rsp);
		end_test();

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 40 ns clock, reset held low for 5 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk;
	end

	initial begin
		o_rst_n <= 1'b0;
		repeat (5) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/periph_top.sv
/*
 * peripheral subsystem top
 * APB splitter with machine timer and UART transmitter
 */

`timescale 1ns/1ps
`default_nettype none

module periph_top (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire periph_pkg::apb_req_t i_apb,
	output periph_pkg::apb_rsp_t o_apb,
	input  wire                  i_dbg_halt,
	output wire                  o_timer_irq,
	output wire                  o_uart_tx
);

	import periph_pkg::*;

	apb_req_t timer_req;
	apb_rsp_t timer_rsp;
	apb_req_t uart_req;
	apb_rsp_t uart_rsp;

	// --------------------
	// address decode
	apb_splitter splitter_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req       (i_apb),
		.o_rsp       (o_apb),
		.o_timer_req (timer_req),
		.i_timer_rsp (timer_rsp),
		.o_uart_req  (uart_req),
		.i_uart_rsp  (uart_rsp)
	);

	// --------------------
	// slaves
	riscv_timer timer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_req       (timer_req),
		.o_rsp       (timer_rsp),
		.i_dbg_halt  (i_dbg_halt),
		.o_timer_irq (o_timer_irq)
	);

	uart_tx_apb uart_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_req     (uart_req),
		.o_rsp     (uart_rsp),
		.o_uart_tx (o_uart_tx)
	);

endmodule

`default_nettype wire

// File: verilog/uart_tx_apb.sv
/*
 * transmit-only UART on APB
 * CSR with busy flag, TXDATA write starts a frame
 * 8N1 shift engine, writes while busy are rejected
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tx_apb (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire periph_pkg::apb_req_t i_req,
	output periph_pkg::apb_rsp_t o_rsp,
	output wire                  o_uart_tx
);

	import periph_pkg::*;

	logic [SLV_SEL_LO-1:0]      ofs;
	logic                       tx_wr;
	logic                       tx_start;
	logic                       tx_reject;
	logic                       busy;
	logic [UART_DIV_W-1:0]      div_cnt;
	logic [UART_IDX_W-1:0]      bit_idx;
	logic [UART_FRAME_BITS-1:0] shift_q;
	logic                       bit_end;
	logic [APB_DATA_W-1:0]      rd_data;

	assign ofs = i_req.paddr[SLV_SEL_LO-1:0];

	// --------------------
	// bus side
	assign tx_wr = i_req.psel && i_req.penable && i_req.pwrite
		&& (ofs == UART_TXDATA);
	assign tx_start  = tx_wr && !busy;
	assign tx_reject = tx_wr && busy;

	always_comb begin
		case (ofs)
			UART_CSR: rd_data = {31'b0, busy};
			default:  rd_data = '0;
		endcase
	end

	assign o_rsp.prdata  = rd_data;
	assign o_rsp.pready  = 1'b1;
	assign o_rsp.pslverr = tx_reject;

	// --------------------
	// shift engine
	assign bit_end = busy && (div_cnt == UART_DIV_W'(UART_DIV - 1));

	// line idles high, so the shifter fills with ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			div_cnt <= '0;
			bit_idx <= '0;
			shift_q <= '1;
		end else if (tx_start) begin
			// stop, data lsb first, start
			shift_q <= {1'b1, i_req.pwdata[7:0], 1'b0};
			busy    <= 1'b1;
			div_cnt <= '0;
			bit_idx <= '0;
		end else if (busy) begin
			if (bit_end) begin
				div_cnt <= '0;
				shift_q <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
				bit_idx <= bit_idx + 1'b1;
				// last bit is the stop bit
				if (bit_idx == UART_IDX_W'(UART_FRAME_BITS - 1)) begin
					busy <= 1'b0;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	assign o_uart_tx = shift_q[0];

endmodule

`default_nettype wire

// File: verilog/riscv_timer.sv
/*
 * RISC-V machine timer on APB
 * tick timebase, 64-bit mtime and mtimecmp
 * enable bit, debug-halt freeze and registered interrupt
 */

`timescale 1ns/1ps
`default_nettype none

module riscv_timer (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire periph_pkg::apb_req_t i_req,
	output periph_pkg::apb_rsp_t o_rsp,
	input  wire                  i_dbg_halt,
	output logic                 o_timer_irq
);

	import periph_pkg::*;

	logic [TICK_CNT_W-1:0] tick_ctr;
	logic                  tick;
	logic                  ctrl_en;
	logic [31:0]           mtime_lo;
	logic [31:0]           mtime_hi;
	logic [31:0]           mtimecmp_lo;
	logic [31:0]           mtimecmp_hi;
	logic [63:0]           mtime_inc;
	logic                  count_en;
	logic [SLV_SEL_LO-1:0] ofs;
	logic                  wr_en;
	logic [APB_DATA_W-1:0] rd_data;

	assign ofs   = i_req.paddr[SLV_SEL_LO-1:0];
	assign wr_en = i_req.psel && i_req.penable && i_req.pwrite;

	// --------------------
	// timebase, one tick pulse per CLK_PER_TICK clocks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= TICK_CNT_W'(CLK_PER_TICK - 1);
			tick     <= 1'b0;
		end else begin
			if (tick_ctr == '0) begin
				tick_ctr <= TICK_CNT_W'(CLK_PER_TICK - 1);
			end else begin
				tick_ctr <= tick_ctr - 1'b1;
			end
			tick <= (tick_ctr == '0);
		end
	end

	// frozen while the hart is halted in debug
	assign count_en  = tick && ctrl_en && !i_dbg_halt;
	assign mtime_inc = {mtime_hi, mtime_lo} + 64'd1;

	// --------------------
	// registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b1;
		end else if (wr_en && ofs == TMR_CTRL) begin
			ctrl_en <= i_req.pwdata[0];
		end
	end

	// bus write wins over the count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime_lo <= '0;
			mtime_hi <= '0;
		end else if (wr_en && ofs == TMR_MTIME) begin
			mtime_lo <= i_req.pwdata;
		end else if (wr_en && ofs == TMR_MTIMEH) begin
			mtime_hi <= i_req.pwdata;
		end else if (count_en) begin
			{mtime_hi, mtime_lo} <= mtime_inc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp_lo <= '1;
			mtimecmp_hi <= '1;
		end else begin
			if (wr_en && ofs == TMR_MTIMECMP) begin
				mtimecmp_lo <= i_req.pwdata;
			end
			if (wr_en && ofs == TMR_MTIMECMPH) begin
				mtimecmp_hi <= i_req.pwdata;
			end
		end
	end

	// unsigned 64-bit compare, one cycle behind the registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_timer_irq <= 1'b0;
		end else begin
			o_timer_irq <= {mtime_hi, mtime_lo} >= {mtimecmp_hi, mtimecmp_lo};
		end
	end

	// --------------------
	// read mux
	always_comb begin
		case (ofs)
			TMR_CTRL:      rd_data = {31'b0, ctrl_en};
			TMR_MTIME:     rd_data = mtime_lo;
			TMR_MTIMEH:    rd_data = mtime_hi;
			TMR_MTIMECMP:  rd_data = mtimecmp_lo;
			TMR_MTIMECMPH: rd_data = mtimecmp_hi;
			default:       rd_data = '0;
		endcase
	end

	// no wait states
	assign o_rsp.prdata  = rd_data;
	assign o_rsp.pready  = 1'b1;
	assign o_rsp.pslverr = 1'b0;

endmodule

`default_nettype wire

// File: verilog/apb_splitter.sv
/*
 * APB address splitter
 * routes one requester to the timer or the UART
 * answers unmapped addresses with an error
 */

`timescale 1ns/1ps
`default_nettype none

module apb_splitter (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire periph_pkg::apb_req_t i_req,
	output periph_pkg::apb_rsp_t o_rsp,
	output periph_pkg::apb_req_t o_timer_req,
	input  wire periph_pkg::apb_rsp_t i_timer_rsp,
	output periph_pkg::apb_req_t o_uart_req,
	input  wire periph_pkg::apb_rsp_t i_uart_rsp
);

	import periph_pkg::*;

	logic [SLV_SEL_W-1:0] sel_dec;
	logic [SLV_SEL_W-1:0] sel_q;
	logic [SLV_SEL_W-1:0] sel;

	assign sel_dec = i_req.paddr[SLV_SEL_HI:SLV_SEL_LO];

	// select is captured in the setup cycle and held for the access cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (i_req.psel && !i_req.penable) begin
			sel_q <= sel_dec;
		end
	end

	assign sel = i_req.penable ? sel_q : sel_dec;

	// --------------------
	// request fan-out, psel only to the chosen slave
	always_comb begin
		o_timer_req      = i_req;
		o_timer_req.psel = i_req.psel && (sel == SLV_TIMER);
		o_uart_req       = i_req;
		o_uart_req.psel  = i_req.psel && (sel == SLV_UART);
	end

	// --------------------
	// response mux
	always_comb begin
		case (sel)
			SLV_TIMER: begin
				o_rsp = i_timer_rsp;
			end
			SLV_UART: begin
				o_rsp = i_uart_rsp;
			end
			default: begin
				// nothing mapped here, complete at once with error
				o_rsp.prdata  = '0;
				o_rsp.pready  = 1'b1;
				o_rsp.pslverr = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/periph_pkg.sv
/*
 * peripheral package
 * APB widths and slave address map
 * timer and UART register offsets
 * timebase and baud divisors, APB request and response structs
 */

`default_nettype none

package periph_pkg;

	// --------------------
	// bus widths
	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	// --------------------
	// slave select field in paddr
	localparam int SLV_SEL_HI = 15;
	localparam int SLV_SEL_LO = 12;
	localparam int SLV_SEL_W  = SLV_SEL_HI - SLV_SEL_LO + 1;

	localparam logic [SLV_SEL_W-1:0] SLV_TIMER = SLV_SEL_W'(0);
	localparam logic [SLV_SEL_W-1:0] SLV_UART  = SLV_SEL_W'(1);

	// --------------------
	// timer registers, one 32-bit word each
	localparam logic [SLV_SEL_LO-1:0] TMR_CTRL      = 12'h000;
	localparam logic [SLV_SEL_LO-1:0] TMR_MTIME     = 12'h008;
	localparam logic [SLV_SEL_LO-1:0] TMR_MTIMEH    = 12'h00c;
	localparam logic [SLV_SEL_LO-1:0] TMR_MTIMECMP  = 12'h010;
	localparam logic [SLV_SEL_LO-1:0] TMR_MTIMECMPH = 12'h014;

	// uart registers
	localparam logic [SLV_SEL_LO-1:0] UART_CSR    = 12'h000;
	localparam logic [SLV_SEL_LO-1:0] UART_TXDATA = 12'h004;

	// --------------------
	// clocks per timer tick, small for simulation
	localparam int CLK_PER_TICK = 4;
	localparam int TICK_CNT_W   = $clog2(CLK_PER_TICK);

	// clocks per uart bit, start + 8 data + stop
	localparam int UART_DIV        = 8;
	localparam int UART_DIV_W      = $clog2(UART_DIV);
	localparam int UART_FRAME_BITS = 10;
	localparam int UART_IDX_W      = $clog2(UART_FRAME_BITS);

	// APB requester side
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	// APB completer side
	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire
